// ==== design/match_queue.sv ====
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module match_queue (
    input  logic                   clk,
    input  logic                   rstn,
    input  tanimoto_pkg::hit_t     i_hit,
    input  logic                   i_out_credit,
    output tanimoto_pkg::id_pair_t o_pair,
    output logic                   o_pair_valid,
    output logic                   o_in_credit
);
    import tanimoto_pkg::*;

    // Depth is a power of two, pointers wrap on their own
    localparam int PTR_W = $clog2(`TANI_MASK_DEPTH);

    hit_t             fifo_mem [`TANI_MASK_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             empty;
    logic             push;
    logic             drop;
    logic             send;
    logic             pop;
    hit_t             head;
    mask_t            done_mask;
    mask_t            pending;
    mask_t            sel_bit;
    ref_idx_t         sel_idx;
    credit_t          out_cred;
    credit_t          ret_cnt;
    credit_t          ret_total;
    logic [1:0]       ret_inc;

    assign full  = (count == (PTR_W + 1)'(`TANI_MASK_DEPTH));
    assign empty = (count == '0);
    assign push  = i_hit.valid && (|i_hit.mask);
    assign drop  = i_hit.valid && !(|i_hit.mask);
    assign head  = fifo_mem[rd_ptr];

    // Lowest unsent reference of the head mask
    always_comb begin
        pending = head.mask & ~done_mask;
        sel_idx = '0;
        for (int i = `TANI_NUM_REFS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel_idx = ref_idx_t'(i);
            end
        end
        sel_bit = mask_t'(1) << sel_idx;
        send    = !empty && (out_cred != '0);
        pop     = send && ((pending & ~sel_bit) == '0);
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= i_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            done_mask <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push);
            rd_ptr <= rd_ptr + PTR_W'(pop);
            count  <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
            if (pop) begin
                done_mask <= '0;
            end else if (send) begin
                done_mask <= done_mask | sel_bit;
            end
        end
    end

    // Output credits saturate instead of wrapping
    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_cred <= '0;
        end else begin
            case ({i_out_credit, send})
                2'b10: begin
                    if (out_cred != '1) begin
                        out_cred <= out_cred + 1'b1;
                    end
                end
                2'b01: out_cred <= out_cred - 1'b1;
                default: out_cred <= out_cred;
            endcase
        end
    end

    // Drop and pop can coincide, so returns queue up one pulse per cycle
    assign ret_inc   = {1'b0, drop} + {1'b0, pop};
    assign ret_total = ret_cnt + credit_t'(ret_inc);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ret_cnt     <= '0;
            o_in_credit <= 1'b0;
        end else begin
            ret_cnt     <= ret_total - credit_t'(ret_total != '0);
            o_in_credit <= (ret_total != '0);
        end
    end

    always_ff @(posedge clk) begin
        o_pair.query_id <= head.id;
        o_pair.ref_idx  <= sel_idx;
        if (!rstn) begin
            o_pair_valid <= 1'b0;
        end else begin
            o_pair_valid <= send;
        end
    end

    // Sender overran its input credits
    a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
        push |-> !full)
        else $error("hit mask pushed into a full FIFO");

    // Head entry keeps an unsent hit until it is popped
    a_head_pending: assert property (@(posedge clk) disable iff (!rstn)
        !empty |-> pending != '0)
        else $error("FIFO head entry has no unsent hit");

endmodule

// ==== design/popcount_tree.sv ====
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module popcount_tree (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_valid,
    input  tanimoto_pkg::vec_t i_vec,
    output logic               o_valid,
    output tanimoto_pkg::cnt_t o_cnt
);
    import tanimoto_pkg::*;

    localparam int NUM_GROUPS = `TANI_VEC_WIDTH / 8;

    logic [3:0] grp_sum_d [NUM_GROUPS];
    logic [3:0] grp_sum_q [NUM_GROUPS];
    logic       valid_q;
    cnt_t       total;

    // Stage 1 counts each byte
    always_comb begin
        for (int g = 0; g < NUM_GROUPS; g++) begin
            grp_sum_d[g] = '0;
            for (int b = 0; b < 8; b++) begin
                grp_sum_d[g] = grp_sum_d[g] + {3'b000, i_vec[g*8+b]};
            end
        end
    end

    always_ff @(posedge clk) begin
        grp_sum_q <= grp_sum_d;
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_valid;
        end
    end

    // Stage 2 adds the byte counts
    always_comb begin
        total = '0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            total = total + cnt_t'(grp_sum_q[g]);
        end
    end

    always_ff @(posedge clk) begin
        o_cnt <= total;
        if (!rstn) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= valid_q;
        end
    end

endmodule

// ==== design/ref_store.sv ====
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module ref_store (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_vec_valid,
    input  tanimoto_pkg::vec_t   i_vec,
    output tanimoto_pkg::query_t o_query,
    output tanimoto_pkg::vec_t   o_ref_vec [`TANI_NUM_REFS],
    output tanimoto_pkg::cnt_t   o_ref_cnt [`TANI_NUM_REFS]
);
    import tanimoto_pkg::*;

    typedef enum logic {
        ST_LOAD,
        ST_COMPARE
    } state_t;

    state_t   state;
    ref_idx_t load_idx;
    qid_t     next_qid;
    vec_t     vec_d1;
    vec_t     vec_d2;
    logic     cnt_valid;
    cnt_t     cnt;
    logic     load_en;
    logic     query_en;

    popcount_tree u_popcount (
        .clk     (clk),
        .rstn    (rstn),
        .i_valid (i_vec_valid),
        .i_vec   (i_vec),
        .o_valid (cnt_valid),
        .o_cnt   (cnt)
    );

    assign load_en  = cnt_valid && (state == ST_LOAD);
    assign query_en = cnt_valid && (state == ST_COMPARE);

    // Vector travels beside the count tree
    always_ff @(posedge clk) begin
        vec_d1 <= i_vec;
        vec_d2 <= vec_d1;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= ST_LOAD;
            load_idx <= '0;
        end else if (load_en) begin
            load_idx <= load_idx + 1'b1;
            if (load_idx == ref_idx_t'(`TANI_NUM_REFS - 1)) begin
                state <= ST_COMPARE;
            end
        end
    end

    // Shift down so slot 0 ends up with the first vector
    always_ff @(posedge clk) begin
        if (load_en) begin
            o_ref_vec[`TANI_NUM_REFS-1] <= vec_d2;
            o_ref_cnt[`TANI_NUM_REFS-1] <= cnt;
            for (int s = 0; s < `TANI_NUM_REFS - 1; s++) begin
                o_ref_vec[s] <= o_ref_vec[s+1];
                o_ref_cnt[s] <= o_ref_cnt[s+1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            next_qid <= '0;
        end else if (query_en) begin
            next_qid <= next_qid + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        o_query.vec <= vec_d2;
        o_query.cnt <= cnt;
        o_query.id  <= next_qid;
        if (!rstn) begin
            o_query.valid <= 1'b0;
        end else begin
            o_query.valid <= query_en;
        end
    end

    a_no_reload: assert property (@(posedge clk) disable iff (!rstn)
        state == ST_COMPARE |=> state == ST_COMPARE)
        else $error("ref_store went back to load without reset");

endmodule

// ==== design/similarity_lane.sv ====
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module similarity_lane (
    input  logic                 clk,
    input  logic                 rstn,
    input  tanimoto_pkg::query_t i_query,
    input  tanimoto_pkg::vec_t   i_ref_vec,
    input  tanimoto_pkg::cnt_t   i_ref_cnt,
    output tanimoto_pkg::cnt_t   o_thr_addr,
    input  tanimoto_pkg::thr_t   i_thr,
    output logic                 o_hit,
    output logic                 o_valid,
    output tanimoto_pkg::qid_t   o_query_id
);
    import tanimoto_pkg::*;

    vec_t and_vec;
    logic and_valid;
    cnt_t and_cnt;
    thr_t sum_d1;
    thr_t sum_d2;
    qid_t id_d1;
    qid_t id_d2;

    assign and_vec = i_query.vec & i_ref_vec;

    popcount_tree u_popcount (
        .clk     (clk),
        .rstn    (rstn),
        .i_valid (i_query.valid),
        .i_vec   (and_vec),
        .o_valid (and_valid),
        .o_cnt   (and_cnt)
    );

    // A+B and query ID wait for the count C
    always_ff @(posedge clk) begin
        sum_d1 <= thr_t'(i_ref_cnt) + thr_t'(i_query.cnt);
        sum_d2 <= sum_d1;
        id_d1  <= i_query.id;
        id_d2  <= id_d1;
    end

    // C selects the threshold entry
    assign o_thr_addr = and_cnt;

    always_ff @(posedge clk) begin
        o_query_id <= id_d2;
        if (!rstn) begin
            o_valid <= 1'b0;
            o_hit   <= 1'b0;
        end else begin
            o_valid <= and_valid;
            o_hit   <= and_valid && (sum_d2 <= i_thr);
        end
    end

endmodule

// ==== design/tanimoto_config.svh ====
`ifndef TANIMOTO_CONFIG_SVH
`define TANIMOTO_CONFIG_SVH

// Fingerprint vector, one bus word
`define TANI_VEC_WIDTH      32
// Population count, 0 up to 32
`define TANI_CNT_WIDTH      6
// A+B sum and threshold entry
`define TANI_SUM_WIDTH      7

// Reference slots, one compare lane each
`define TANI_NUM_REFS       4
`define TANI_REF_ID_WIDTH   2

`define TANI_ID_WIDTH       8

// Hit-mask FIFO depth, equal to the sender's starting credits
`define TANI_MASK_DEPTH     4
`define TANI_CREDIT_WIDTH   4

`endif

// ==== design/tanimoto_pkg.sv ====
`include "tanimoto_config.svh"

package tanimoto_pkg;

    typedef logic [`TANI_VEC_WIDTH-1:0]    vec_t;
    typedef logic [`TANI_CNT_WIDTH-1:0]    cnt_t;
    typedef logic [`TANI_SUM_WIDTH-1:0]    thr_t;
    typedef logic [`TANI_ID_WIDTH-1:0]     qid_t;
    typedef logic [`TANI_REF_ID_WIDTH-1:0] ref_idx_t;
    typedef logic [`TANI_NUM_REFS-1:0]     mask_t;
    typedef logic [`TANI_CREDIT_WIDTH-1:0] credit_t;

    // Query broadcast to all lanes
    typedef struct packed {
        logic valid;
        vec_t vec;
        cnt_t cnt;
        qid_t id;
    } query_t;

    // One bit per reference, bit i for slot i
    typedef struct packed {
        logic  valid;
        qid_t  id;
        mask_t mask;
    } hit_t;

    typedef struct packed {
        qid_t     query_id;
        ref_idx_t ref_idx;
    } id_pair_t;

    typedef struct packed {
        logic en;
        cnt_t addr;
        thr_t data;
    } thr_wr_t;

endpackage

// ==== design/tanimoto_top.sv ====
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module tanimoto_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_vec_valid,
    input  tanimoto_pkg::vec_t     i_vec,
    input  tanimoto_pkg::thr_wr_t  i_thr_wr,
    input  logic                   i_out_credit,
    output tanimoto_pkg::id_pair_t o_pair,
    output logic                   o_pair_valid,
    output logic                   o_in_credit
);

    tanimoto_pkg::query_t     query;
    tanimoto_pkg::vec_t       ref_vec  [`TANI_NUM_REFS];
    tanimoto_pkg::cnt_t       ref_cnt  [`TANI_NUM_REFS];
    tanimoto_pkg::cnt_t       thr_addr [`TANI_NUM_REFS];
    tanimoto_pkg::thr_t       thr_data [`TANI_NUM_REFS];
    logic [`TANI_NUM_REFS-1:0] lane_hit;
    logic [`TANI_NUM_REFS-1:0] lane_valid;
    tanimoto_pkg::qid_t       lane_qid [`TANI_NUM_REFS];
    tanimoto_pkg::hit_t       hit;

    ref_store u_ref_store (
        .clk         (clk),
        .rstn        (rstn),
        .i_vec_valid (i_vec_valid),
        .i_vec       (i_vec),
        .o_query     (query),
        .o_ref_vec   (ref_vec),
        .o_ref_cnt   (ref_cnt)
    );

    threshold_table u_threshold_table (
        .clk       (clk),
        .rstn      (rstn),
        .i_thr_wr  (i_thr_wr),
        .i_rd_addr (thr_addr),
        .o_rd_data (thr_data)
    );

    for (genvar l = 0; l < `TANI_NUM_REFS; l++) begin : g_lane
        similarity_lane u_lane (
            .clk        (clk),
            .rstn       (rstn),
            .i_query    (query),
            .i_ref_vec  (ref_vec[l]),
            .i_ref_cnt  (ref_cnt[l]),
            .o_thr_addr (thr_addr[l]),
            .i_thr      (thr_data[l]),
            .o_hit      (lane_hit[l]),
            .o_valid    (lane_valid[l]),
            .o_query_id (lane_qid[l])
        );
    end

    // All lanes run in lockstep, lane 0 carries valid and ID
    assign hit = '{valid: lane_valid[0], id: lane_qid[0], mask: lane_hit};

    match_queue u_match_queue (
        .clk          (clk),
        .rstn         (rstn),
        .i_hit        (hit),
        .i_out_credit (i_out_credit),
        .o_pair       (o_pair),
        .o_pair_valid (o_pair_valid),
        .o_in_credit  (o_in_credit)
    );

endmodule

// ==== design/threshold_table.sv ====
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module threshold_table (
    input  logic                  clk,
    input  logic                  rstn,
    input  tanimoto_pkg::thr_wr_t i_thr_wr,
    input  tanimoto_pkg::cnt_t    i_rd_addr [`TANI_NUM_REFS],
    output tanimoto_pkg::thr_t    o_rd_data [`TANI_NUM_REFS]
);
    import tanimoto_pkg::*;

    // One entry per possible C value, 0 to VEC_WIDTH
    localparam int NUM_ENTRIES = `TANI_VEC_WIDTH + 1;

    thr_t entries [NUM_ENTRIES];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int e = 0; e < NUM_ENTRIES; e++) begin
                entries[e] <= '0;
            end
        end else if (i_thr_wr.en && (int'(i_thr_wr.addr) < NUM_ENTRIES)) begin
            entries[i_thr_wr.addr] <= i_thr_wr.data;
        end
    end

    // Combinational read, one port per lane
    always_comb begin
        for (int l = 0; l < `TANI_NUM_REFS; l++) begin
            if (int'(i_rd_addr[l]) < NUM_ENTRIES) begin
                o_rd_data[l] = entries[i_rd_addr[l]];
            end else begin
                o_rd_data[l] = '0;
            end
        end
    end

endmodule

// ==== dv/tanimoto_tb.sv ====
`timescale 1ns/1ps
`include "tanimoto_config.svh"

module tanimoto_tb;
    import tanimoto_pkg::*;

    // Tanimoto bound t = T_NUM / T_DEN for the main table
    localparam int T_NUM          = 1;
    localparam int T_DEN          = 2;
    localparam int NUM_ENTRIES    = `TANI_VEC_WIDTH + 1;
    localparam int CYCLES_PER_ROW = 40;

    typedef enum {
        OP_LOAD,
        OP_QUERY,
        OP_HOLD,
        OP_RELEASE,
        OP_THR_MAIN,
        OP_THR_EDGE
    } op_t;

    typedef struct {
        string name;
        op_t   op;
        vec_t  vec;
        mask_t exp_mask;
    } row_t;

    typedef struct {
        string    name;
        id_pair_t pair;
    } exp_pair_t;

    logic     clk;
    logic     rstn;
    logic     i_vec_valid;
    vec_t     i_vec;
    thr_wr_t  i_thr_wr;
    logic     i_out_credit;
    id_pair_t o_pair;
    logic     o_pair_valid;
    logic     o_in_credit;

    row_t      rows [$];
    exp_pair_t exp_q [$];
    vec_t      ref_model [`TANI_NUM_REFS];
    int        thr_model [NUM_ENTRIES];
    int        errors        = 0;
    int        checked       = 0;
    int        sent          = 0;
    int        returned      = 0;
    int        grant_every   = 0;
    int        timeout_limit = 0;
    logic      hold_on       = 1'b0;

    tb_clock_gen u_clock_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    tanimoto_top dut (
        .clk          (clk),
        .rstn         (rstn),
        .i_vec_valid  (i_vec_valid),
        .i_vec        (i_vec),
        .i_thr_wr     (i_thr_wr),
        .i_out_credit (i_out_credit),
        .o_pair       (o_pair),
        .o_pair_valid (o_pair_valid),
        .o_in_credit  (o_in_credit)
    );

    function automatic void add_row(input string name, input op_t op, input vec_t vec);
        row_t r;
        r.name     = name;
        r.op       = op;
        r.vec      = vec;
        r.exp_mask = '0;
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        add_row("thr_t_half", OP_THR_MAIN, '0);
        add_row("ref0", OP_LOAD, 32'h0000_00FF);
        add_row("ref1", OP_LOAD, 32'h0F0F_0F0F);
        add_row("ref2", OP_LOAD, 32'hFFFF_0000);
        add_row("ref3", OP_LOAD, 32'hFFFF_FFFF);
        // Output credits withheld while these queries wait in the FIFO
        add_row("hold", OP_HOLD, '0);
        add_row("hold_eq_ref1", OP_QUERY, 32'h0F0F_0F0F);
        add_row("hold_rand_a", OP_QUERY, vec_t'($urandom()));
        add_row("hold_eq_ref0", OP_QUERY, 32'h0000_00FF);
        add_row("hold_rand_b", OP_QUERY, vec_t'($urandom()));
        add_row("release", OP_RELEASE, '0);
        add_row("no_hit", OP_QUERY, '0);
        add_row("eq_ref2", OP_QUERY, 32'hFFFF_0000);
        add_row("rand_c", OP_QUERY, vec_t'($urandom()));
        add_row("rand_d", OP_QUERY, vec_t'($urandom()));
        add_row("rand_e", OP_QUERY, vec_t'($urandom()));
        add_row("eq_ref3", OP_QUERY, 32'hFFFF_FFFF);
        // Only C = 32 can hit with this table
        add_row("thr_edge", OP_THR_EDGE, '0);
        add_row("edge_ones", OP_QUERY, 32'hFFFF_FFFF);
        add_row("edge_ref1", OP_QUERY, 32'h0F0F_0F0F);
        add_row("edge_rand", OP_QUERY, vec_t'($urandom()));
    endfunction

    function automatic int thr_entry(input bit edge_table, input int c);
        if (edge_table) begin
            return (c == `TANI_VEC_WIDTH) ? 2 * `TANI_VEC_WIDTH : 0;
        end
        // C*(1+t)/t, rounded down
        return c * (T_DEN + T_NUM) / T_NUM;
    endfunction

    // Hit when A + B is at most the entry addressed by C
    function automatic mask_t expect_mask(input vec_t q);
        mask_t m;
        int    a;
        int    b;
        int    c;
        m = '0;
        b = $countones(q);
        for (int r = 0; r < `TANI_NUM_REFS; r++) begin
            a = $countones(ref_model[r]);
            c = $countones(ref_model[r] & q);
            if (a + b <= thr_model[c]) begin
                m[r] = 1'b1;
            end
        end
        return m;
    endfunction

    function automatic void fill_expected();
        int loaded;
        loaded = 0;
        foreach (rows[i]) begin
            case (rows[i].op)
                OP_LOAD: begin
                    ref_model[loaded] = rows[i].vec;
                    loaded++;
                end
                OP_THR_MAIN, OP_THR_EDGE: begin
                    for (int c = 0; c < NUM_ENTRIES; c++) begin
                        thr_model[c] = thr_entry(rows[i].op == OP_THR_EDGE, c);
                    end
                end
                OP_QUERY: rows[i].exp_mask = expect_mask(rows[i].vec);
                default: ;
            endcase
        end
    endfunction

    task automatic send_vec(input vec_t vec);
        @(posedge clk);
        i_vec_valid <= 1'b1;
        i_vec       <= vec;
        @(posedge clk);
        i_vec_valid <= 1'b0;
    endtask

    task automatic program_table(input bit edge_table);
        for (int c = 0; c < NUM_ENTRIES; c++) begin
            @(posedge clk);
            i_thr_wr <= '{en: 1'b1, addr: cnt_t'(c), data: thr_t'(thr_entry(edge_table, c))};
        end
        @(posedge clk);
        i_thr_wr <= '0;
    endtask

    // No query in flight and every pair seen
    task automatic wait_drained();
        while (exp_q.size() != 0 || returned != sent) begin
            @(posedge clk);
        end
    endtask

    task automatic apply_row(input row_t row);
        exp_pair_t want;
        case (row.op)
            OP_LOAD: send_vec(row.vec);
            OP_QUERY: begin
                // Sender spends one input credit per query
                while (sent - returned >= `TANI_MASK_DEPTH) begin
                    @(posedge clk);
                end
                for (int r = 0; r < `TANI_NUM_REFS; r++) begin
                    if (row.exp_mask[r]) begin
                        want.name          = row.name;
                        want.pair.query_id = qid_t'(sent);
                        want.pair.ref_idx  = ref_idx_t'(r);
                        exp_q.push_back(want);
                    end
                end
                sent++;
                send_vec(row.vec);
            end
            OP_HOLD: begin
                hold_on     <= 1'b1;
                grant_every <= 0;
            end
            OP_RELEASE: begin
                // Long enough for every held query to reach the FIFO
                repeat (20) @(posedge clk);
                hold_on     <= 1'b0;
                grant_every <= 3;
                while (exp_q.size() != 0) begin
                    @(posedge clk);
                end
                grant_every <= 1;
            end
            OP_THR_MAIN: begin
                wait_drained();
                program_table(1'b0);
            end
            OP_THR_EDGE: begin
                wait_drained();
                program_table(1'b1);
            end
            default: ;
        endcase
    endtask

    task automatic finish_run();
        $display("Errors: %0d, pairs checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // Output credit pulses, one every grant_every cycles, none when zero
    initial begin
        int phase;
        phase        = 0;
        i_out_credit = 1'b0;
        forever begin
            @(posedge clk);
            if (!rstn || grant_every == 0) begin
                i_out_credit <= 1'b0;
                phase = 0;
            end else if (phase + 1 >= grant_every) begin
                i_out_credit <= 1'b1;
                phase = 0;
            end else begin
                i_out_credit <= 1'b0;
                phase++;
            end
        end
    end

    // Pair and credit monitor
    initial begin
        exp_pair_t want;
        forever begin
            @(posedge clk);
            if (rstn && o_in_credit) begin
                returned <= returned + 1;
            end
            if (rstn && o_pair_valid) begin
                assert (!hold_on) else begin
                    errors++;
                    $display("A pair came out while output credits were withheld");
                end
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("Pair %0d/%0d arrived when no pair was expected",
                             o_pair.query_id, o_pair.ref_idx);
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    checked++;
                    assert (o_pair == want.pair) else begin
                        errors++;
                        $display("FAILED %s: expected %0d/%0d, actual %0d/%0d", want.name,
                                 want.pair.query_id, want.pair.ref_idx,
                                 o_pair.query_id, o_pair.ref_idx);
                    end
                end
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        wait (timeout_limit != 0);
        while (cycles < timeout_limit) begin
            @(posedge clk);
            cycles++;
        end
        errors++;
        $display("Timeout, the run did not finish within %0d cycles", timeout_limit);
        finish_run();
    end

    initial begin
        void'($urandom(81));
        i_vec_valid = 1'b0;
        i_vec       = '0;
        i_thr_wr    = '0;
        build_table();
        fill_expected();
        timeout_limit = rows.size() * CYCLES_PER_ROW;
        wait (rstn === 1'b1);
        // Idle after reset, nothing may come out
        repeat (8) begin
            @(posedge clk);
            assert (!o_pair_valid && !o_in_credit) else begin
                errors++;
                $display("Pair valid or input credit went high with no query sent");
            end
        end
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        wait_drained();
        repeat (10) @(posedge clk);
        assert (returned == sent) else begin
            errors++;
            $display("FAILED credit_total: expected %0d, actual %0d", sent, returned);
        end
        finish_run();
    end

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held low across the first two rising edges
    initial begin
        rstn = 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// ==== files.f ====
+incdir+design
design/tanimoto_pkg.sv
design/popcount_tree.sv
design/ref_store.sv
design/threshold_table.sv
design/similarity_lane.sv
design/match_queue.sv
design/tanimoto_top.sv
dv/tb_clock_gen.sv
dv/tanimoto_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tanimoto_tb -o tanimoto_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tanimoto_sim | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "TEST OK" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0
